// ==== flist.f ====
+incdir+design
design/l2_cache_pkg.sv
design/l2_tag_array.sv
design/l2_lru.sv
design/l2_cache_ctrl.sv
design/l2_cache.sv
dv/tb_mem_model.sv
dv/l2_cache_checker.sv
dv/tb_l2_cache.sv

// ==== dv/tb_l2_cache.sv ====
`timescale 1ns/1ns

`include "l2_cache_macros.svh"

`default_nettype none

module tb_l2_cache import l2_cache_pkg::*; ();

    localparam int SEED           = 32'ha884_0fd2;
    localparam int N_RANDOM       = 250;
    localparam int TIMEOUT_CYCLES = (N_RANDOM + 50) * 40 + 8000;  // 40 cycles worst per access

    logic       CLK;
    logic       nRST;
    logic       proc_ren;
    logic       proc_wen;
    word_t      proc_addr;
    word_t      proc_wdata;
    logic [3:0] proc_byte_en;
    logic       proc_busy;
    word_t      proc_rdata;
    logic       mem_ren;
    logic       mem_wen;
    word_t      mem_addr;
    word_t      mem_wdata;
    logic [3:0] mem_byte_en;
    logic       mem_busy;
    word_t      mem_rdata;

    word_t      shadow [2048];  // expected memory image
    logic       beat_wr_q [$];  // completed memory beats
    word_t      beat_addr_q [$];
    word_t      beat_data_q [$];
    logic [3:0] beat_be_q [$];
    int         cycles;
    integer     seed;

    l2_cache UUT (.*);

    tb_mem_model #(.SEED(SEED)) u_mem (
        .CLK, .mem_ren, .mem_wen, .mem_addr, .mem_wdata, .mem_byte_en,
        .mem_busy, .mem_rdata
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model and compares
    //////////////////////////////////////////////////////////////////////

    function automatic int mem_index(word_t addr);
        return {addr[31], addr[11:2]};
    endfunction

    function automatic word_t merge_bytes(word_t old_word, word_t new_word, logic [3:0] be);
        word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // touched way goes behind the others, slot 0 is the victim
    function automatic logic [7:0] move_to_back(logic [7:0] order, way_idx_t way);
        logic [7:0] result;
        int         n;
        result = '0;
        n      = 0;
        for (int i = 0; i < 4; i++) begin
            if (order[2*i +: 2] != way) begin
                result[2*n +: 2] = order[2*i +: 2];
                n++;
            end
        end
        result[7:6] = way;
        return result;
    endfunction

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_way(string name, way_idx_t got, way_idx_t exp);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // logs memory beats, checks reads and tracks writes
    always @(posedge CLK) begin
        if (nRST && (mem_ren || mem_wen) && !mem_busy) begin
            beat_wr_q.push_back(mem_wen);
            beat_addr_q.push_back(mem_addr);
            beat_data_q.push_back(mem_wdata);
            beat_be_q.push_back(mem_byte_en);
        end
        if (nRST && proc_ren && !proc_busy) begin
            check_word($sformatf("proc_rdata at %h", proc_addr), proc_rdata,
                       shadow[mem_index(proc_addr)]);
        end
        if (nRST && proc_wen && !proc_busy) begin
            shadow[mem_index(proc_addr)] = merge_bytes(shadow[mem_index(proc_addr)],
                                                       proc_wdata, proc_byte_en);
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (UUT.u_checker.fail_count != 0) begin
            report_failure("a memory bus protocol assertion failed");
        end else if (cycles >= TIMEOUT_CYCLES) begin
            report_failure("timeout: the cache stopped answering before the tests ended");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // processor bus
    //////////////////////////////////////////////////////////////////////

    task automatic bus_access(input logic wr, input word_t addr, input word_t wdata,
                              input logic [3:0] be, output word_t rdata);
        @(negedge CLK);
        proc_ren     = !wr;
        proc_wen     = wr;
        proc_addr    = addr;
        proc_wdata   = wdata;
        proc_byte_en = be;
        do begin
            @(posedge CLK);
        end while (proc_busy);
        rdata = proc_rdata;
        @(negedge CLK);
        proc_ren = 1'b0;
        proc_wen = 1'b0;
    endtask

    task automatic read_word(input word_t addr, output word_t rdata);
        bus_access(1'b0, addr, '0, 4'hf, rdata);
    endtask

    task automatic write_word(input word_t addr, input word_t wdata, input logic [3:0] be);
        word_t unused;
        bus_access(1'b1, addr, wdata, be, unused);
    endtask

    task automatic clear_beats();
        beat_wr_q.delete();
        beat_addr_q.delete();
        beat_data_q.delete();
        beat_be_q.delete();
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_miss_then_hit();
        word_t base;
        word_t rd;
        base = 32'h0000_0120;  // set 2
        clear_beats();
        read_word(base + 32'h4, rd);
        check_word("fill beat count", word_t'(beat_addr_q.size()), 32'd4);
        for (int i = 0; i < 4; i++) begin
            check_bit("mem_wen", beat_wr_q[i], 1'b0);
            check_word("mem_addr", beat_addr_q[i], base + word_t'(4*i));  // ascending
        end
        clear_beats();
        read_word(base + 32'h4, rd);
        check_word("hit beat count", word_t'(beat_addr_q.size()), 32'd0);
    endtask

    task automatic test_write_merge();
        word_t addr;
        word_t old_word;
        word_t rd;
        addr     = 32'h0000_0128;
        old_word = shadow[mem_index(addr)];
        clear_beats();
        write_word(addr, 32'hdead_beef, 4'b0101);
        check_word("write hit beat count", word_t'(beat_addr_q.size()), 32'd0);
        read_word(addr, rd);
        check_word("proc_rdata", rd, merge_bytes(old_word, 32'hdead_beef, 4'b0101));
    endtask

    task automatic test_lru_and_writeback();
        logic [7:0] order;
        way_idx_t   line_way [5];
        word_t      base [5];
        word_t      rd;
        int         evicted;
        order = 8'he4;  // 0, 1, 2, 3 from the front
        for (int k = 0; k < 5; k++) begin
            base[k] = word_t'((k + 1) * 128) + 32'h50;  // set 5, tags 1 to 5
        end
        for (int k = 0; k < 4; k++) begin
            line_way[k] = order[1:0];
            order       = move_to_back(order, order[1:0]);
            write_word(base[k] + word_t'(4*k), 32'h1111_0000 + word_t'(k), 4'hf);
        end
        read_word(base[0], rd);
        order = move_to_back(order, line_way[0]);
        clear_beats();
        read_word(base[4], rd);
        check_word("evict beat count", word_t'(beat_addr_q.size()), 32'd8);
        evicted = -1;
        for (int k = 0; k < 4; k++) begin
            if (beat_addr_q[0] == base[k]) begin
                evicted = k;
            end
        end
        if (evicted < 0) begin
            report_failure("write-back address belongs to none of the filled lines");
        end else begin
            check_way("victim way", line_way[evicted], way_idx_t'(order[1:0]));
            for (int i = 0; i < 4; i++) begin
                check_bit("mem_wen", beat_wr_q[i], 1'b1);
                check_word("mem_addr", beat_addr_q[i], base[evicted] + word_t'(4*i));
                check_word("mem_wdata", beat_data_q[i],
                           shadow[mem_index(base[evicted] + word_t'(4*i))]);
                check_word("mem_byte_en", word_t'(beat_be_q[i]), 32'hf);
            end
            read_word(base[evicted] + word_t'(4*evicted), rd);  // back from memory
            check_word("proc_rdata", rd, 32'h1111_0000 + word_t'(evicted));
        end
    endtask

    task automatic test_pass_through();
        word_t addr;
        word_t rd;
        addr = `L2_NONCACHE_BASE + 32'h238;
        clear_beats();
        read_word(addr, rd);
        check_word("uncached beat count", word_t'(beat_addr_q.size()), 32'd1);
        check_bit("mem_wen", beat_wr_q[0], 1'b0);
        check_word("mem_addr", beat_addr_q[0], addr);
        addr = `L2_NONCACHE_BASE + 32'h104;
        clear_beats();
        write_word(addr, 32'hcafe_f00d, 4'b0110);
        check_word("uncached beat count", word_t'(beat_addr_q.size()), 32'd1);
        check_bit("mem_wen", beat_wr_q[0], 1'b1);
        check_word("mem_addr", beat_addr_q[0], addr);
        check_word("mem_wdata", beat_data_q[0], 32'hcafe_f00d);
        check_word("mem_byte_en", word_t'(beat_be_q[0]), 32'h6);
        clear_beats();
        read_word(addr, rd);
        check_word("uncached beat count", word_t'(beat_addr_q.size()), 32'd1);  // no line kept
    endtask

    task automatic test_random_mix();
        word_t r;
        word_t addr;
        word_t rd;
        for (int n = 0; n < N_RANDOM; n++) begin
            r    = $random(seed);
            addr = {r[31], 19'b0, r[11:2], 2'b00};  // both regions, 4 KB each
            if (r[12]) begin
                write_word(addr, $random(seed), r[16:13]);
            end else begin
                read_word(addr, rd);
            end
        end
    endtask

    initial begin
        seed         = SEED;
        cycles       = 0;
        nRST         = 1'b0;
        proc_ren     = 1'b0;
        proc_wen     = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        proc_byte_en = '0;
        #1;
        for (int i = 0; i < 2048; i++) begin
            shadow[i] = u_mem.mem[i];
        end
        repeat (8) @(negedge CLK);
        nRST = 1'b1;
        test_miss_then_hit();
        test_write_merge();
        test_lru_and_writeback();
        test_pass_through();
        test_random_mix();
        if (UUT.u_checker.fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            report_failure("a memory bus protocol assertion failed");
        end
    end

endmodule

`default_nettype wire

// ==== dv/l2_cache_checker.sv ====
`timescale 1ns/1ns

`default_nettype none

module l2_cache_checker import l2_cache_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  mem_ren,
    input  logic  mem_wen,
    input  logic  mem_busy,
    input  word_t mem_addr
);

    int fail_count = 0;  // failed assertions so far

    // one request kind per beat
    a_one_request: assert property (
        @(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen)
    ) else begin
        $error("mem_ren and mem_wen are high together");
        fail_count++;
    end

    a_quiet_in_reset: assert property (
        @(posedge CLK) !nRST |-> (!mem_ren && !mem_wen)
    ) else begin
        $error("memory request raised during reset");
        fail_count++;
    end

    // stalled beat keeps its address
    a_addr_stable: assert property (
        @(posedge CLK) disable iff (!nRST)
        ((mem_ren || mem_wen) && mem_busy) |=> $stable(mem_addr)
    ) else begin
        $error("mem_addr changed while mem_busy was high");
        fail_count++;
    end

endmodule

bind l2_cache l2_cache_checker u_checker (
    .CLK, .nRST, .mem_ren, .mem_wen, .mem_busy, .mem_addr
);

`default_nettype wire

// ==== dv/tb_mem_model.sv ====
`timescale 1ns/1ns

`default_nettype none

module tb_mem_model import l2_cache_pkg::*; #(
    parameter int SEED = 0
) (
    input  logic       CLK,
    input  logic       mem_ren,
    input  logic       mem_wen,
    input  word_t      mem_addr,
    input  word_t      mem_wdata,
    input  logic [3:0] mem_byte_en,
    output logic       mem_busy,
    output word_t      mem_rdata
);

    word_t       mem [2048];  // low 4 KB of each region
    word_t       full_addr;
    logic [10:0] idx;
    integer      seed;

    assign idx       = {mem_addr[31], mem_addr[11:2]};  // region bit on top
    assign mem_rdata = mem[idx];

    initial begin
        seed     = SEED;
        mem_busy = 1'b0;
        for (int i = 0; i < 2048; i++) begin
            full_addr = {i[10], 19'b0, i[9:0], 2'b00};
            mem[i]    = full_addr ^ {full_addr[15:0], full_addr[31:16]} ^ 32'h3c5a_96e1;
        end
    end

    // about one stall in four
    always @(negedge CLK) begin
        mem_busy <= (($random(seed) & 3) == 0);
    end

    always @(posedge CLK) begin
        if (mem_wen && !mem_busy) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_byte_en[b]) begin
                    mem[idx][8*b +: 8] <= mem_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/l2_cache.sv ====
`timescale 1ns/1ns

`include "l2_cache_macros.svh"

`default_nettype none

module l2_cache import l2_cache_pkg::*; (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     proc_ren,
    input  logic                     proc_wen,
    input  word_t                    proc_addr,
    input  word_t                    proc_wdata,
    input  logic [`L2_WORD_W/8-1:0]  proc_byte_en,
    output logic                     proc_busy,
    output word_t                    proc_rdata,
    output logic                     mem_ren,
    output logic                     mem_wen,
    output word_t                    mem_addr,
    output word_t                    mem_wdata,
    output logic [`L2_WORD_W/8-1:0]  mem_byte_en,
    input  logic                     mem_busy,
    input  word_t                    mem_rdata
);

    localparam int LINE_LSB = `L2_OFF_W + 2;

    set_idx_t  set_idx;
    tag_t      tag;
    word_idx_t word_idx;
    logic      pass_through;
    logic      hit;
    way_idx_t  hit_way;
    way_idx_t  victim_way;
    word_t     rd_word;
    logic      victim_dirty;
    tag_t      victim_tag;
    line_t     victim_line;
    logic      fill_we;
    word_idx_t fill_word;
    word_t     fill_data;
    logic      fill_done;
    logic      wr_hit;
    word_t     wr_data;
    logic [`L2_WORD_W/8-1:0] wr_byte_en;
    logic      clean;
    logic      lru_access;
    logic      lru_miss;

    // tag | set | word offset | byte
    assign tag          = proc_addr[`L2_WORD_W-1 -: `L2_TAG_W];
    assign set_idx      = proc_addr[LINE_LSB +: `L2_SET_W];
    assign word_idx     = proc_addr[2 +: `L2_OFF_W];
    assign pass_through = (proc_addr >= `L2_NONCACHE_BASE);

    //////////////////////////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////////////////////////

    l2_tag_array u_tag_array (
        .CLK, .nRST, .set_idx, .tag, .word_idx, .victim_way,
        .hit, .hit_way, .rd_word, .victim_dirty, .victim_tag, .victim_line,
        .fill_we, .fill_word, .fill_data, .fill_done,
        .wr_hit, .wr_data, .wr_byte_en, .clean
    );

    l2_lru u_lru (
        .CLK, .nRST, .set_idx,
        .access (lru_access),
        .miss   (lru_miss),
        .hit_way, .victim_way
    );

    l2_cache_ctrl u_ctrl (
        .CLK, .nRST, .proc_ren, .proc_wen, .pass_through, .proc_addr, .proc_wdata,
        .proc_byte_en, .proc_busy, .proc_rdata,
        .hit, .rd_word, .victim_dirty, .victim_tag, .victim_line,
        .fill_we, .fill_word, .fill_data, .fill_done,
        .wr_hit, .wr_data, .wr_byte_en, .clean, .lru_access, .lru_miss,
        .mem_ren, .mem_wen, .mem_addr, .mem_wdata, .mem_byte_en, .mem_busy, .mem_rdata
    );

endmodule

`default_nettype wire

// ==== design/l2_cache_ctrl.sv ====
`timescale 1ns/1ns

`include "l2_cache_macros.svh"

`default_nettype none

module l2_cache_ctrl import l2_cache_pkg::*; (
    input  logic                     CLK,
    input  logic                     nRST,
    // processor side
    input  logic                     proc_ren,
    input  logic                     proc_wen,
    input  logic                     pass_through,
    input  word_t                    proc_addr,
    input  word_t                    proc_wdata,
    input  logic [`L2_WORD_W/8-1:0]  proc_byte_en,
    output logic                     proc_busy,
    output word_t                    proc_rdata,
    // tag array
    input  logic                     hit,
    input  word_t                    rd_word,
    input  logic                     victim_dirty,
    input  tag_t                     victim_tag,
    input  line_t                    victim_line,
    output logic                     fill_we,
    output word_idx_t                fill_word,
    output word_t                    fill_data,
    output logic                     fill_done,
    output logic                     wr_hit,
    output word_t                    wr_data,
    output logic [`L2_WORD_W/8-1:0]  wr_byte_en,
    output logic                     clean,
    // replacement
    output logic                     lru_access,
    output logic                     lru_miss,
    // memory side
    output logic                     mem_ren,
    output logic                     mem_wen,
    output word_t                    mem_addr,
    output word_t                    mem_wdata,
    output logic [`L2_WORD_W/8-1:0]  mem_byte_en,
    input  logic                     mem_busy,
    input  word_t                    mem_rdata
);

    localparam int        LINE_LSB  = `L2_OFF_W + 2;
    localparam word_idx_t LAST_WORD = word_idx_t'(`L2_BLOCK_WORDS - 1);

    l2_state_e state, next_state;
    word_idx_t word_cnt, next_word_cnt;
    word_t     beat_addr, next_beat_addr;  // address of the current memory beat
    logic      req;
    set_idx_t  req_set;
    word_t     fetch_base;
    word_t     wb_base;

    assign req        = proc_ren | proc_wen;
    assign req_set    = proc_addr[LINE_LSB +: `L2_SET_W];
    assign fetch_base = {proc_addr[`L2_WORD_W-1:LINE_LSB], {LINE_LSB{1'b0}}};
    assign wb_base    = {victim_tag, req_set, {LINE_LSB{1'b0}}};

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            word_cnt  <= '0;
            beat_addr <= '0;
        end else begin
            state     <= next_state;
            word_cnt  <= next_word_cnt;
            beat_addr <= next_beat_addr;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // next state and outputs
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state     = state;
        next_word_cnt  = word_cnt;
        next_beat_addr = beat_addr;
        proc_busy      = 1'b1;
        proc_rdata     = '0;
        mem_ren        = 1'b0;
        mem_wen        = 1'b0;
        mem_addr       = beat_addr;
        mem_wdata      = victim_line[word_cnt];
        mem_byte_en    = '1;                       // line beats are full words
        fill_we        = 1'b0;
        fill_word      = word_cnt;
        fill_data      = mem_rdata;
        fill_done      = 1'b0;
        wr_hit         = 1'b0;
        wr_data        = proc_wdata;
        wr_byte_en     = proc_byte_en;
        clean          = 1'b0;
        lru_access     = 1'b0;
        lru_miss       = 1'b0;

        case (state)
            IDLE: begin
                if (req && pass_through) begin
                    mem_ren     = proc_ren;            // single uncached beat
                    mem_wen     = proc_wen;
                    mem_addr    = proc_addr;
                    mem_wdata   = proc_wdata;
                    mem_byte_en = proc_byte_en;
                    proc_busy   = mem_busy;
                    proc_rdata  = mem_rdata;
                end else if (req && hit) begin
                    proc_busy  = 1'b0;
                    proc_rdata = rd_word;
                    wr_hit     = proc_wen;
                    lru_access = 1'b1;
                end else if (req) begin
                    next_word_cnt = '0;
                    if (victim_dirty) begin
                        next_state     = WRITEBACK;
                        next_beat_addr = wb_base;
                    end else begin
                        next_state     = FETCH;
                        next_beat_addr = fetch_base;
                    end
                end
            end
            WRITEBACK: begin
                mem_wen = 1'b1;
                if (!mem_busy) begin
                    next_word_cnt  = word_cnt + 1'b1;
                    next_beat_addr = beat_addr + word_t'(4);
                    if (word_cnt == LAST_WORD) begin
                        clean          = 1'b1;
                        next_state     = FETCH;
                        next_beat_addr = fetch_base;
                    end
                end
            end
            FETCH: begin
                mem_ren = 1'b1;
                if (!mem_busy) begin
                    fill_we        = 1'b1;
                    next_word_cnt  = word_cnt + 1'b1;
                    next_beat_addr = beat_addr + word_t'(4);
                    if (word_cnt == LAST_WORD) begin
                        // victim leaves the front once the new line is in place
                        fill_done  = 1'b1;
                        lru_access = 1'b1;
                        lru_miss   = 1'b1;
                        next_state = IDLE;             // access hits next cycle
                    end
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/l2_lru.sv ====
`timescale 1ns/1ns

`include "l2_cache_macros.svh"

`default_nettype none

module l2_lru import l2_cache_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  set_idx_t set_idx,
    input  logic     access,
    input  logic     miss,
    input  way_idx_t hit_way,
    output way_idx_t victim_way
);

    // front of each list is least recently used
    way_idx_t order_q [`L2_N_SETS][`L2_ASSOC];
    way_idx_t next_order [`L2_ASSOC];
    way_idx_t move_way;
    logic     shifting;

    assign victim_way = order_q[set_idx][0];

    //////////////////////////////////////////////////////////////////////
    // reorder the indexed set
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        move_way   = miss ? order_q[set_idx][0] : hit_way;  // way going to the back
        next_order = order_q[set_idx];
        shifting   = 1'b0;
        for (int i = 0; i < `L2_ASSOC - 1; i++) begin
            if (order_q[set_idx][i] == move_way) begin
                shifting = 1'b1;                   // close the gap from here on
            end
            if (shifting) begin
                next_order[i] = order_q[set_idx][i+1];
            end
        end
        next_order[`L2_ASSOC-1] = move_way;        // most recently used
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < `L2_N_SETS; s++) begin
                for (int i = 0; i < `L2_ASSOC; i++) begin
                    order_q[s][i] <= way_idx_t'(i);  // 0, 1, 2, 3
                end
            end
        end else if (access) begin
            order_q[set_idx] <= next_order;
        end
    end

endmodule

`default_nettype wire

// ==== design/l2_tag_array.sv ====
`timescale 1ns/1ns

`include "l2_cache_macros.svh"

`default_nettype none

module l2_tag_array import l2_cache_pkg::*; (
    input  logic                     CLK,
    input  logic                     nRST,
    input  set_idx_t                 set_idx,
    input  tag_t                     tag,
    input  word_idx_t                word_idx,
    input  way_idx_t                 victim_way,
    output logic                     hit,
    output way_idx_t                 hit_way,
    output word_t                    rd_word,
    output logic                     victim_dirty,
    output tag_t                     victim_tag,
    output line_t                    victim_line,
    input  logic                     fill_we,
    input  word_idx_t                fill_word,
    input  word_t                    fill_data,
    input  logic                     fill_done,
    input  logic                     wr_hit,
    input  word_t                    wr_data,
    input  logic [`L2_WORD_W/8-1:0]  wr_byte_en,
    input  logic                     clean
);

    logic [`L2_ASSOC-1:0] valid_q [`L2_N_SETS];
    logic [`L2_ASSOC-1:0] dirty_q [`L2_N_SETS];
    tag_t                 tag_mem [`L2_N_SETS][`L2_ASSOC];
    line_t                data_mem [`L2_N_SETS][`L2_ASSOC];

    //////////////////////////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `L2_ASSOC; w++) begin
            if (valid_q[set_idx][w] && (tag_mem[set_idx][w] == tag)) begin
                hit     = 1'b1;
                hit_way = way_idx_t'(w);
            end
        end
    end

    assign rd_word      = data_mem[set_idx][hit_way][word_idx];
    assign victim_dirty = valid_q[set_idx][victim_way] & dirty_q[set_idx][victim_way];
    assign victim_tag   = tag_mem[set_idx][victim_way];
    assign victim_line  = data_mem[set_idx][victim_way];

    //////////////////////////////////////////////////////////////////////
    // line state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '{default: '0};  // all lines invalid
            dirty_q <= '{default: '0};
        end else begin
            if (fill_done) begin
                valid_q[set_idx][victim_way] <= 1'b1;
                dirty_q[set_idx][victim_way] <= 1'b0;  // fresh copy of memory
            end else if (clean) begin
                dirty_q[set_idx][victim_way] <= 1'b0;  // victim written back
            end
            if (wr_hit) begin
                dirty_q[set_idx][hit_way] <= 1'b1;
            end
        end
    end

    // tags and words
    always_ff @(posedge CLK) begin
        if (fill_we) begin
            data_mem[set_idx][victim_way][fill_word] <= fill_data;
        end else if (wr_hit) begin
            for (int b = 0; b < `L2_WORD_W/8; b++) begin
                if (wr_byte_en[b]) begin
                    data_mem[set_idx][hit_way][word_idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
        if (fill_done) begin
            tag_mem[set_idx][victim_way] <= tag;
        end
    end

endmodule

`default_nettype wire

// ==== design/l2_cache_pkg.sv ====
`include "l2_cache_macros.svh"

`default_nettype none

package l2_cache_pkg;

    // bus and address field types
    typedef logic [`L2_WORD_W-1:0] word_t;
    typedef logic [`L2_TAG_W-1:0]  tag_t;
    typedef logic [`L2_SET_W-1:0]  set_idx_t;
    typedef logic [`L2_OFF_W-1:0]  word_idx_t;
    typedef logic [$clog2(`L2_ASSOC)-1:0] way_idx_t;

    // one cache line, word 0 in the low slot
    typedef word_t [`L2_BLOCK_WORDS-1:0] line_t;

    // miss handling states
    typedef enum logic [1:0] {
        IDLE,       // hits, pass-through, miss detection
        WRITEBACK,  // dirty victim out to memory
        FETCH       // requested line in from memory
    } l2_state_e;

endpackage

`default_nettype wire

// ==== design/l2_cache_macros.svh ====
`ifndef L2_CACHE_MACROS_SVH
`define L2_CACHE_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////////////////////////

`define L2_WORD_W        32             // processor and memory word

//////////////////////////////////////////////////////////////////////
// cache geometry
//////////////////////////////////////////////////////////////////////

`define L2_BLOCK_WORDS   4              // words per line
`define L2_ASSOC         4              // ways per set
`define L2_N_SETS        8
`define L2_OFF_W         2              // word offset bits
`define L2_SET_W         3              // set index bits
`define L2_TAG_W         25             // word - set - offset - byte bits

//////////////////////////////////////////////////////////////////////
// address map
//////////////////////////////////////////////////////////////////////

`define L2_NONCACHE_BASE 32'h8000_0000  // everything above bypasses the cache

`endif
